//--- hw/rename_pkg.sv
`default_nettype none

package rename_pkg;

	// machine widths.
	localparam int lanes = 3;
	localparam int arch_regs = 32;
	localparam int phys_regs = 64;

	// registers that are not mapped at any time.
	localparam int free_depth = phys_regs - arch_regs;

	typedef logic [$clog2(arch_regs)-1:0] arch_t;
	typedef logic [$clog2(phys_regs)-1:0] phys_t;

	// free-list pointer and occupancy. occupancy counts up to a full list.
	typedef logic [$clog2(free_depth)-1:0] ptr_t;
	typedef logic [$clog2(free_depth):0] count_t;

	// one bit per lane, lane 2 holds the oldest instruction.
	typedef logic [lanes-1:0] lane_mask_t;

	// whole architectural-to-physical table.
	typedef phys_t [arch_regs-1:0] map_image_t;

endpackage

`default_nettype wire

//--- hw/free_if.sv
`timescale 1ns/10ps
`default_nettype none

interface free_if
	import rename_pkg::*;
();

	lane_mask_t alloc_en; // only set for an accepted group.
	phys_t [lanes-1:0] alloc_phys;
	lane_mask_t alloc_avail; // thermometer from lane 2 down.
	lane_mask_t release_en;
	phys_t [lanes-1:0] release_phys;
	logic recover;

	modport pool (
		input alloc_en,
		input release_en,
		input release_phys,
		input recover,
		output alloc_phys,
		output alloc_avail
	);

	modport allocator (
		input alloc_phys,
		input alloc_avail,
		output alloc_en
	);

	modport releaser (
		output release_en,
		output release_phys
	);

endinterface

`default_nettype wire

//--- hw/free_list.sv
`timescale 1ns/10ps
`default_nettype none

module free_list
	import rename_pkg::*;
(
	input logic clock,
	input logic reset,
	free_if.pool pool,
	output count_t free_count
);

	phys_t [free_depth-1:0] entries;
	phys_t [free_depth-1:0] entries_next;
	ptr_t head;
	ptr_t head_next;
	ptr_t tail;
	ptr_t tail_next;
	logic full;
	logic full_next;
	count_t count;

	// head and tail meet both when empty and when full.
	assign count = full ? count_t'(free_depth) : {1'b0, tail - head};
	assign free_count = count;

	always_comb begin
		for (int i = 0; i < lanes; i++) begin
			pool.alloc_avail[i] = count > count_t'(lanes - 1 - i);
		end
	end

	// oldest enabled lane takes the head, younger ones follow.
	always_comb begin
		ptr_t rd_ptr;
		rd_ptr = head;
		for (int i = lanes - 1; i >= 0; i--) begin
			pool.alloc_phys[i] = entries[rd_ptr];
			if (pool.alloc_en[i]) begin
				rd_ptr = rd_ptr + 1'b1;
			end
		end
		head_next = rd_ptr;
	end

	// released registers go in at the tail in retirement order.
	always_comb begin
		ptr_t wr_ptr;
		wr_ptr = tail;
		entries_next = entries;
		for (int i = lanes - 1; i >= 0; i--) begin
			if (pool.release_en[i]) begin
				entries_next[wr_ptr] = pool.release_phys[i];
				wr_ptr = wr_ptr + 1'b1;
			end
		end
		tail_next = wr_ptr;
	end

	// only a release can fill the list; allocating down to the tail empties it.
	assign full_next = (pool.release_en != '0 || full) && (tail_next == head_next);

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			full <= 1'b1;
			for (int i = 0; i < free_depth; i++) begin
				entries[i] <= phys_t'(arch_regs + i); // registers above the arch range.
			end
		end else if (pool.recover) begin
			// every speculative allocation comes back at once.
			entries <= entries_next;
			head <= tail_next;
			tail <= tail_next;
			full <= 1'b1;
		end else begin
			entries <= entries_next;
			head <= head_next;
			tail <= tail_next;
			full <= full_next;
		end
	end

endmodule

`default_nettype wire

//--- hw/map_table.sv
`timescale 1ns/10ps
`default_nettype none

module map_table
	import rename_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic recover,
	input lane_mask_t dispatch_valid,
	input arch_t [lanes-1:0] dispatch_dest,
	input arch_t [lanes-1:0] dispatch_src1,
	input arch_t [lanes-1:0] dispatch_src2,
	input map_image_t committed_image,
	free_if.allocator alloc,
	output logic dispatch_ready,
	output phys_t [lanes-1:0] dispatch_phys,
	output phys_t [lanes-1:0] dispatch_old_phys,
	output phys_t [lanes-1:0] dispatch_src1_phys,
	output phys_t [lanes-1:0] dispatch_src2_phys
);

	map_image_t table_q;
	map_image_t table_next;
	count_t valid_n;
	count_t avail_n;
	logic accept;

	always_comb begin
		valid_n = '0;
		avail_n = '0;
		for (int i = 0; i < lanes; i++) begin
			valid_n = valid_n + count_t'(dispatch_valid[i]);
			avail_n = avail_n + count_t'(alloc.alloc_avail[i]);
		end
	end

	// whole group or nothing; a recovering cycle takes no group.
	assign accept = !recover && (valid_n <= avail_n);
	assign dispatch_ready = accept;
	assign alloc.alloc_en = accept ? dispatch_valid : '0;

	assign dispatch_phys = alloc.alloc_phys;

	// read the table, then let each older writer override in age order.
	// the last override is the youngest older lane, which is the right producer.
	always_comb begin
		for (int i = 0; i < lanes; i++) begin
			dispatch_src1_phys[i] = table_q[dispatch_src1[i]];
			dispatch_src2_phys[i] = table_q[dispatch_src2[i]];
			dispatch_old_phys[i] = table_q[dispatch_dest[i]];
			for (int j = lanes - 1; j > i; j--) begin
				if (dispatch_valid[j] && dispatch_dest[j] == dispatch_src1[i]) begin
					dispatch_src1_phys[i] = alloc.alloc_phys[j];
				end
				if (dispatch_valid[j] && dispatch_dest[j] == dispatch_src2[i]) begin
					dispatch_src2_phys[i] = alloc.alloc_phys[j];
				end
				if (dispatch_valid[j] && dispatch_dest[j] == dispatch_dest[i]) begin
					dispatch_old_phys[i] = alloc.alloc_phys[j];
				end
			end
		end
	end

	// oldest lane writes first so a younger write to the same register wins.
	always_comb begin
		table_next = table_q;
		for (int j = lanes - 1; j >= 0; j--) begin
			if (alloc.alloc_en[j]) begin
				table_next[dispatch_dest[j]] = alloc.alloc_phys[j];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < arch_regs; i++) begin
				table_q[i] <= phys_t'(i); // identity map.
			end
		end else if (recover) begin
			table_q <= committed_image;
		end else begin
			table_q <= table_next;
		end
	end

endmodule

`default_nettype wire

//--- hw/arch_map.sv
`timescale 1ns/10ps
`default_nettype none

module arch_map
	import rename_pkg::*;
(
	input logic clock,
	input logic reset,
	input lane_mask_t retire_valid,
	input arch_t [lanes-1:0] retire_arch,
	input phys_t [lanes-1:0] retire_phys,
	free_if.releaser free_release,
	output map_image_t committed_image
);

	map_image_t table_q;
	map_image_t table_next;

	assign free_release.release_en = retire_valid;

	// a retiring lane frees whatever its register held just before it.
	// inside a group that can be an older lane's new register.
	always_comb begin
		for (int i = 0; i < lanes; i++) begin
			free_release.release_phys[i] = table_q[retire_arch[i]];
			for (int j = lanes - 1; j > i; j--) begin
				if (retire_valid[j] && retire_arch[j] == retire_arch[i]) begin
					free_release.release_phys[i] = retire_phys[j];
				end
			end
		end
	end

	always_comb begin
		table_next = table_q;
		for (int j = lanes - 1; j >= 0; j--) begin
			if (retire_valid[j]) begin
				table_next[retire_arch[j]] = retire_phys[j];
			end
		end
	end

	// recovery sees this cycle's retirements too.
	assign committed_image = table_next;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < arch_regs; i++) begin
				table_q[i] <= phys_t'(i);
			end
		end else begin
			table_q <= table_next;
		end
	end

endmodule

`default_nettype wire

//--- hw/rename_top.sv
`timescale 1ns/10ps
`default_nettype none

module rename_top
	import rename_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic recover,
	input lane_mask_t dispatch_valid,
	input arch_t [lanes-1:0] dispatch_dest,
	input arch_t [lanes-1:0] dispatch_src1,
	input arch_t [lanes-1:0] dispatch_src2,
	output logic dispatch_ready,
	output phys_t [lanes-1:0] dispatch_phys,
	output phys_t [lanes-1:0] dispatch_old_phys,
	output phys_t [lanes-1:0] dispatch_src1_phys,
	output phys_t [lanes-1:0] dispatch_src2_phys,
	input lane_mask_t retire_valid,
	input arch_t [lanes-1:0] retire_arch,
	input phys_t [lanes-1:0] retire_phys,
	output count_t free_count
);

	map_image_t committed_image;

	free_if u_free_if ();

	assign u_free_if.recover = recover;

	free_list u_free_list (
		.clock(clock),
		.reset(reset),
		.pool(u_free_if.pool),
		.free_count(free_count)
	);

	map_table u_map_table (
		.clock(clock),
		.reset(reset),
		.recover(recover),
		.dispatch_valid(dispatch_valid),
		.dispatch_dest(dispatch_dest),
		.dispatch_src1(dispatch_src1),
		.dispatch_src2(dispatch_src2),
		.committed_image(committed_image),
		.alloc(u_free_if.allocator),
		.dispatch_ready(dispatch_ready),
		.dispatch_phys(dispatch_phys),
		.dispatch_old_phys(dispatch_old_phys),
		.dispatch_src1_phys(dispatch_src1_phys),
		.dispatch_src2_phys(dispatch_src2_phys)
	);

	arch_map u_arch_map (
		.clock(clock),
		.reset(reset),
		.retire_valid(retire_valid),
		.retire_arch(retire_arch),
		.retire_phys(retire_phys),
		.free_release(u_free_if.releaser),
		.committed_image(committed_image)
	);

endmodule

`default_nettype wire

//--- dv/rename_checker.sv
`timescale 1ns/10ps
`default_nettype none

module rename_checker
	import rename_pkg::*;
(
	input logic clock,
	input logic reset,
	input count_t free_count,
	input lane_mask_t alloc_en,
	input lane_mask_t alloc_avail,
	input lane_mask_t release_en,
	input logic full,
	input ptr_t head,
	input ptr_t tail
);

	int assert_failures = 0;

	// releasing past the free slots would wrap the tail over the head.
	count_bound: assert property (@(posedge clock) disable iff (reset)
		int'(free_count) - $countones(alloc_en) + $countones(release_en) <= free_depth)
		else begin
			assert_failures++;
			$error("free list would hold more than %0d registers", free_depth);
		end

	// a group may use any lanes, but never more of them than are free.
	alloc_bound: assert property (@(posedge clock) disable iff (reset)
		$countones(alloc_en) <= $countones(alloc_avail))
		else begin
			assert_failures++;
			$error("more registers taken than the free list offers");
		end

	full_pointers: assert property (@(posedge clock) disable iff (reset)
		full |-> head == tail)
		else begin
			assert_failures++;
			$error("free list marked full while head and tail differ");
		end

endmodule

bind free_list rename_checker u_checker (
	.clock(clock),
	.reset(reset),
	.free_count(free_count),
	.alloc_en(pool.alloc_en),
	.alloc_avail(pool.alloc_avail),
	.release_en(pool.release_en),
	.full(full),
	.head(head),
	.tail(tail)
);

`default_nettype wire

//--- dv/rename_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module rename_monitor
	import rename_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic recover,
	input lane_mask_t dispatch_valid,
	input arch_t [lanes-1:0] dispatch_dest,
	input arch_t [lanes-1:0] dispatch_src1,
	input arch_t [lanes-1:0] dispatch_src2,
	input logic dispatch_ready,
	input phys_t [lanes-1:0] dispatch_phys,
	input phys_t [lanes-1:0] dispatch_old_phys,
	input phys_t [lanes-1:0] dispatch_src1_phys,
	input phys_t [lanes-1:0] dispatch_src2_phys,
	input lane_mask_t retire_valid,
	input arch_t [lanes-1:0] retire_arch,
	input phys_t [lanes-1:0] retire_phys,
	input count_t free_count
);

	phys_t spec_map [arch_regs];
	phys_t comm_map [arch_regs];
	phys_t free_q [$]; // registers ready to hand out, head first.
	phys_t inflight_q [$]; // handed out and not yet retired, in allocation order.
	int error_count = 0;
	int check_count = 0;
	int test_count = 0;
	int test_checks = 0;
	int test_errors = 0;

	task automatic compare(input string what, input int lane, input int got, input int exp);
		check_count++;
		test_checks++;
		if (got != exp) begin
			error_count++;
			test_errors++;
			$display("error %0t: %s lane %0d got %0d, expected %0d", $time, what, lane, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic report();
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
	endtask

	// mid-cycle the inputs and the combinational outputs are both settled.
	always @(negedge clock) begin
		phys_t view [arch_regs];
		phys_t fresh;
		bit exp_ready;
		if (reset) begin
			for (int i = 0; i < arch_regs; i++) begin
				spec_map[i] = phys_t'(i);
				comm_map[i] = phys_t'(i);
			end
			free_q.delete();
			inflight_q.delete();
			for (int i = arch_regs; i < phys_regs; i++) begin
				free_q.push_back(phys_t'(i));
			end
		end else begin
			exp_ready = !recover && $countones(dispatch_valid) <= free_q.size();
			compare("free_count", 0, free_count, free_q.size());
			compare("dispatch_ready", 0, dispatch_ready, exp_ready);
			if (exp_ready && dispatch_ready) begin
				view = spec_map;
				// rename in program order, each lane sees the ones before it.
				for (int j = lanes - 1; j >= 0; j--) begin
					if (dispatch_valid[j]) begin
						fresh = free_q.pop_front();
						compare("src1_phys", j, dispatch_src1_phys[j], view[dispatch_src1[j]]);
						compare("src2_phys", j, dispatch_src2_phys[j], view[dispatch_src2[j]]);
						compare("old_phys", j, dispatch_old_phys[j], view[dispatch_dest[j]]);
						compare("new phys", j, dispatch_phys[j], fresh);
						for (int a = 0; a < arch_regs; a++) begin
							if (view[a] == dispatch_phys[j]
								|| comm_map[a] == dispatch_phys[j]) begin
								error_count++;
								test_errors++;
								$display("error %0t: register %0d handed out while still mapped",
									$time, dispatch_phys[j]);
							end
						end
						view[dispatch_dest[j]] = fresh;
						inflight_q.push_back(fresh);
					end
				end
				spec_map = view;
			end
			for (int j = lanes - 1; j >= 0; j--) begin
				if (retire_valid[j]) begin
					free_q.push_back(comm_map[retire_arch[j]]);
					comm_map[retire_arch[j]] = retire_phys[j];
					if (inflight_q.size() > 0) begin
						void'(inflight_q.pop_front());
					end
				end
			end
			// squashed registers come back ahead of the free ones.
			if (recover) begin
				spec_map = comm_map;
				for (int k = inflight_q.size() - 1; k >= 0; k--) begin
					free_q.push_front(inflight_q[k]);
				end
				inflight_q.delete();
			end
		end
	end

endmodule

`default_nettype wire

//--- dv/rename_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rename_tb
	import rename_pkg::*;
();

	localparam int period = 40;
	localparam int reset_cycles = 5;
	localparam int random_cycles = 300;
	localparam int stall_cycles = 24;
	localparam int drain_cycles = 24;
	localparam int recover_rounds = 4;
	localparam int round_cycles = 18;
	localparam int total_cycles = reset_cycles + 3 + random_cycles + stall_cycles
		+ drain_cycles + recover_rounds * round_cycles + 1;

	logic clock;
	logic reset;
	logic recover;
	lane_mask_t dispatch_valid;
	arch_t [lanes-1:0] dispatch_dest;
	arch_t [lanes-1:0] dispatch_src1;
	arch_t [lanes-1:0] dispatch_src2;
	logic dispatch_ready;
	phys_t [lanes-1:0] dispatch_phys;
	phys_t [lanes-1:0] dispatch_old_phys;
	phys_t [lanes-1:0] dispatch_src1_phys;
	phys_t [lanes-1:0] dispatch_src2_phys;
	lane_mask_t retire_valid;
	arch_t [lanes-1:0] retire_arch;
	phys_t [lanes-1:0] retire_phys;
	count_t free_count;

	// accepted instructions waiting to retire, oldest first.
	arch_t pending_arch [$];
	phys_t pending_phys [$];

	rename_top u_rename_top (.*);
	rename_monitor u_monitor (.*);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	// half the picks come from a few registers so that groups collide.
	function automatic arch_t pick_arch();
		if ($urandom_range(0, 1) == 0) begin
			return arch_t'($urandom_range(0, 3));
		end
		return arch_t'($urandom_range(0, arch_regs - 1));
	endfunction

	task automatic drive_group(input lane_mask_t mask);
		dispatch_valid = mask;
		for (int j = 0; j < lanes; j++) begin
			dispatch_dest[j] = pick_arch();
			dispatch_src1[j] = pick_arch();
			dispatch_src2[j] = pick_arch();
		end
	endtask

	task automatic drive_retire(input int n);
		retire_valid = '0;
		for (int k = 0; k < lanes; k++) begin
			if (k < n && pending_arch.size() > 0) begin
				retire_valid[lanes - 1 - k] = 1'b1; // lane 2 is the oldest.
				retire_arch[lanes - 1 - k] = pending_arch.pop_front();
				retire_phys[lanes - 1 - k] = pending_phys.pop_front();
			end
		end
	endtask

	task automatic step();
		@(negedge clock);
		if (dispatch_ready) begin
			for (int j = lanes - 1; j >= 0; j--) begin
				if (dispatch_valid[j]) begin
					pending_arch.push_back(dispatch_dest[j]);
					pending_phys.push_back(dispatch_phys[j]);
				end
			end
		end
		if (recover) begin
			pending_arch.delete();
			pending_phys.delete();
		end
		@(posedge clock);
		#2;
	endtask

	initial begin
		void'($urandom(32'h3ad9_b38e));
		reset = 1'b1;
		recover = 1'b0;
		dispatch_valid = '0;
		dispatch_dest = '0;
		dispatch_src1 = '0;
		dispatch_src2 = '0;
		retire_valid = '0;
		retire_arch = '0;
		retire_phys = '0;
		repeat (reset_cycles) @(posedge clock);
		#2;
		reset = 1'b0;
		dispatch_valid = 3'b111;
		for (int j = 0; j < lanes; j++) begin
			dispatch_dest[j] = arch_t'(j + 1);
			dispatch_src1[j] = arch_t'(j + 10);
			dispatch_src2[j] = arch_t'(j + 20);
		end
		step();
		drive_group(3'b000);
		step();
		u_monitor.end_test("reset_map");
		repeat (random_cycles) begin
			drive_group(lane_mask_t'($urandom_range(0, 7)));
			drive_retire($urandom_range(0, 3));
			step();
		end
		u_monitor.end_test("random_groups");
		drive_retire(0);
		for (int k = 0; k < stall_cycles - 4 && free_count >= count_t'(lanes); k++) begin
			drive_group(3'b111);
			step();
		end
		drive_group(3'b111); // wider than what is left.
		repeat (4) step();
		u_monitor.end_test("stall");
		drive_group(3'b000);
		repeat (drain_cycles) begin
			drive_retire(lanes);
			step();
		end
		u_monitor.end_test("retire_drain");
		repeat (recover_rounds) begin
			repeat (round_cycles - 2) begin
				drive_group(lane_mask_t'($urandom_range(0, 7)));
				drive_retire($urandom_range(0, 3));
				step();
			end
			drive_group(3'b111);
			drive_retire($urandom_range(0, 3));
			recover = 1'b1;
			step();
			recover = 1'b0;
			drive_group(3'b111);
			drive_retire(0);
			step();
		end
		u_monitor.end_test("recover");
		drive_group(3'b000);
		step();
		u_monitor.report();
		if (u_monitor.error_count == 0
			&& u_rename_top.u_free_list.u_checker.assert_failures == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		repeat (2 * total_cycles) @(posedge clock);
		$display("watchdog: test sequence still running after %0d cycles", 2 * total_cycles);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
hw/rename_pkg.sv
hw/free_if.sv
hw/free_list.sv
hw/map_table.sv
hw/arch_map.sv
hw/rename_top.sv
dv/rename_checker.sv
dv/rename_monitor.sv
dv/rename_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = rename_tb
FILELIST = build.f
OBJ_DIR = obj_dir
LOG = sim.log

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

.PHONY: sim clean
